//--- tb.f
logic/rv_mul_pkg.sv
logic/mul_issue.sv
logic/mul_unit.sv
logic/mul_wb_queue.sv
logic/rv_mul_top.sv
verification/rv_mul_assert.sv
verification/rv_mul_checker.sv
verification/rv_mul_tb.sv

//--- Makefile
# Verilator build and run of the RV32M multiply testbench

TOP := rv_mul_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		-f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

//--- verification/rv_mul_tb.sv
// Testbench for the RV32M multiply subsystem
// Directed table plus xorshift rows under random result back-pressure

module rv_mul_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_DIR  = 16;             // Directed rows
    localparam int N_ROWS = N_DIR + 200;
    localparam int FILL_N = 7;              // Issue + 2 stages + 4 queue

    logic                 clk = 1'b0;
    logic                 rst;
    rv_mul_pkg::mul_req_t req;
    logic                 req_valid;
    logic                 req_ready;
    rv_mul_pkg::mul_res_t res;
    logic                 res_valid;
    logic                 res_ready;

    rv_mul_pkg::funct3_t op_tab   [N_ROWS];
    rv_mul_pkg::xlen_t   rs1_tab  [N_ROWS];
    rv_mul_pkg::xlen_t   rs2_tab  [N_ROWS];
    rv_mul_pkg::xlen_t   exp_tab  [N_ROWS]; // Directed rows only
    string               name_tab [N_ROWS];

    logic [31:0] rnd_state = 32'd77;
    logic        fill_hold;                 // Keeps res_ready low at start
    logic        seen;
    int          tb_errs;
    int          total;

    always #4 clk = ~clk;

    rv_mul_top u_rv_mul_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    rv_mul_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    bind rv_mul_top rv_mul_assert u_rv_mul_assert (
        .clk         (clk),
        .rst         (rst),
        .req_ready   (req_ready),
        .res         (res),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .wb_res      (wb_res),
        .wb_valid    (wb_valid),
        .wb_accepted (wb_accepted)
    );

    function automatic logic [31:0] next_random();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 17);
        rnd_state = rnd_state ^ (rnd_state << 5);
        return rnd_state;
    endfunction

    task automatic set_row(input int i, input rv_mul_pkg::funct3_t op,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] e, input string name);
        op_tab[i]   = op;
        rs1_tab[i]  = a;
        rs2_tab[i]  = b;
        exp_tab[i]  = e;
        name_tab[i] = name;
    endtask

    ////////////////////
    // Stimulus table
    task automatic load_table();
        set_row(0,  3'd0, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000, "mul_zero");
        set_row(1,  3'd0, 32'h0000_0001, 32'h0000_0001, 32'h0000_0001, "mul_ones");
        set_row(2,  3'd0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, "mul_all_ones");
        set_row(3,  3'd0, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000, "mul_min_min");
        set_row(4,  3'd0, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA, "mul_neg_pos");
        set_row(5,  3'd1, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000, "mulh_min_min");
        set_row(6,  3'd1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, "mulh_all_ones");
        set_row(7,  3'd1, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF, "mulh_neg_pos");
        set_row(8,  3'd1, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF, "mulh_max_max");
        set_row(9,  3'd2, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, "mulhsu_neg_big");
        set_row(10, 3'd2, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000, "mulhsu_min_min");
        set_row(11, 3'd2, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000, "mulhsu_one_big");
        set_row(12, 3'd3, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, "mulhu_all_ones");
        set_row(13, 3'd3, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000, "mulhu_min_min");
        set_row(14, 3'd7, 32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001, "remu_as_mulhu");
        set_row(15, 3'd3, 32'h0001_0000, 32'h0001_0000, 32'h0000_0001, "mulhu_carry");
        for (int i = N_DIR; i < N_ROWS; i++) begin
            set_row(i, 3'(next_random()), next_random(), next_random(), '0,
                    $sformatf("rand_%0d", i));  // Any funct3 since only the low bits decode
        end
    endtask

    task automatic send_row(input int i);
        rv_mul_pkg::mul_req_t r;
        r.op     = op_tab[i];
        r.rs1    = rs1_tab[i];
        r.rs2    = rs2_tab[i];
        r.rd_tag = rv_mul_pkg::tag_t'(i % 32);
        @(negedge clk);
        req       = r;
        req_valid = 1'b1;
        do @(posedge clk); while (!req_ready);
        u_checker.push_expect(name_tab[i], r, i < N_DIR, exp_tab[i]);
    endtask

    ////////////////////
    // Back-pressure of about one stall in four
    initial begin
        res_ready = 1'b0;
        @(negedge clk iff !rst);
        forever begin
            @(negedge clk);
            res_ready = !fill_hold && (next_random() & 32'h3) != 0;
        end
    end

    // Watchdog
    initial begin
        repeat (N_ROWS * 20 + 100) @(posedge clk);
        $display("Timeout: run did not complete within %0d cycles", N_ROWS * 20 + 100);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        fill_hold = 1'b1;
        tb_errs   = 0;
        seen      = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // req_ready must rise while nothing comes out yet
        for (int k = 0; k < 8 && !seen; k++) begin
            @(posedge clk);
            if (res_valid) begin
                $display("res_valid went high before any request");
                tb_errs++;
            end
            seen = req_ready;
        end
        if (!seen) begin
            $display("req_ready did not rise after reset");
            tb_errs++;
        end

        for (int i = 0; i < N_ROWS; i++) begin
            send_row(i);
            if (i == FILL_N - 1) begin      // All slots taken so the core must stall
                @(negedge clk);
                req_valid = 1'b0;
                repeat (3) begin
                    @(posedge clk);
                    if (req_ready || !res_valid) begin
                        $display("Pipeline did not stall with %0d results held", FILL_N);
                        tb_errs++;
                    end
                end
                fill_hold = 1'b0;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;

        while (u_checker.pending() != 0) @(negedge clk);
        repeat (10) @(posedge clk);         // Any extra result gets flagged

        total = u_checker.value_errs + u_checker.other_errs + tb_errs
              + u_rv_mul_top.u_rv_mul_assert.fail_count;
        $display("Errors: %0d value, %0d other, %0d testbench, %0d assert, %0d results",
                 u_checker.value_errs, u_checker.other_errs, tb_errs,
                 u_rv_mul_top.u_rv_mul_assert.fail_count, u_checker.results);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verification/rv_mul_checker.sv
// Result checker for the RV32M multiply subsystem
// Predicts each result from the M extension rule and compares in order

module rv_mul_checker (
    input logic                 clk,
    input logic                 rst,
    input rv_mul_pkg::mul_res_t res,
    input logic                 res_valid,
    input logic                 res_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    rv_mul_pkg::mul_res_t exp_q [$];        // Expected results, issue order
    string                name_q [$];       // Test name per entry
    rv_mul_pkg::mul_res_t head_exp;
    string                head_name;

    int value_errs = 0;                     // Wrong word or tag
    int other_errs = 0;                     // Extra results and the like
    int results    = 0;

    ////////////////////
    // Reference model
    // Extend, full 64-bit multiply, pick the word
    function automatic rv_mul_pkg::xlen_t predict(input rv_mul_pkg::mul_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] p;
        logic        a_signed;
        logic        b_signed;
        case (r.op[1:0])
            2'd0:    {a_signed, b_signed} = 2'b11;  // MUL, low word
            2'd1:    {a_signed, b_signed} = 2'b11;  // MULH
            2'd2:    {a_signed, b_signed} = 2'b10;  // MULHSU
            default: {a_signed, b_signed} = 2'b00;  // MULHU
        endcase
        a = a_signed ? {{32{r.rs1[31]}}, r.rs1} : {32'h0, r.rs1};
        b = b_signed ? {{32{r.rs2[31]}}, r.rs2} : {32'h0, r.rs2};
        p = a * b;                          // Mod 2^64 is enough
        return (r.op[1:0] == 2'd0) ? p[31:0] : p[63:32];
    endfunction

    // Called by the testbench for every accepted request
    task automatic push_expect(input string name, input rv_mul_pkg::mul_req_t r,
                               input logic use_tab, input rv_mul_pkg::xlen_t tab_word);
        rv_mul_pkg::mul_res_t e;
        e.rd     = use_tab ? tab_word : predict(r);
        e.rd_tag = r.rd_tag;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    ////////////////////
    // Compare on every result transfer
    always @(posedge clk) begin
        if (!rst && res_valid && res_ready) begin
            results++;
            if (exp_q.size() == 0) begin
                $display("Result with tag %0d arrived with no request outstanding",
                         res.rd_tag);
                other_errs++;
            end else begin
                head_exp  = exp_q.pop_front();
                head_name = name_q.pop_front();
                if (res.rd !== head_exp.rd) begin
                    $display("ERR %s: expected %08h, actual %08h",
                             head_name, head_exp.rd, res.rd);
                    value_errs++;
                end
                if (res.rd_tag !== head_exp.rd_tag) begin  // Order or tag slip
                    $display("ERR %s tag: expected %0d, actual %0d",
                             head_name, head_exp.rd_tag, res.rd_tag);
                    value_errs++;
                end
            end
        end
    end

endmodule

//--- verification/rv_mul_assert.sv
// Handshake and overflow assertions for the multiply subsystem
// Bound to the top level to watch the queue boundaries

module rv_mul_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_ready,
    input rv_mul_pkg::mul_res_t res,
    input logic                 res_valid,
    input logic                 res_ready,
    input rv_mul_pkg::mul_res_t wb_res,
    input logic                 wb_valid,
    input logic                 wb_accepted
);
    timeunit 1ns;
    timeprecision 100ps;

    logic       wr;
    logic       rd;
    logic [3:0] occ;                        // Shadow queue occupancy
    int         fail_count = 0;             // Failed assertions so far

    assign wr = wb_valid & wb_accepted;
    assign rd = res_valid & res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= '0;
        end else begin
            occ <= occ + 4'(wr) - 4'(rd);
        end
    end

    ////////////////////
    // Stalled outputs hold
    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else begin
            fail_count++;
            $error("res changed or dropped while stalled");
        end

    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_accepted |=> wb_valid && $stable(wb_res))
        else begin
            fail_count++;
            $error("multiplier result changed while refused");
        end

    // Full queue without a read takes nothing
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        occ == 4'(rv_mul_pkg::WB_DEPTH) && !rd |-> !wr)
        else begin
            fail_count++;
            $error("write into full write-back queue");
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !res_valid && !req_ready)
        else begin
            fail_count++;
            $error("handshake active during reset");
        end

endmodule

//--- logic/rv_mul_top.sv
// RV32M multiply execution subsystem
// Issue stage, two-stage multiplier and write-back queue in series

module rv_mul_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_mul_pkg::mul_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output rv_mul_pkg::mul_res_t res,
    output logic                 res_valid,
    input  logic                 res_ready
);

    rv_mul_pkg::mul_ops_t ops;              // Issue to multiplier
    logic                 issue_valid;
    logic                 issue_ready;
    rv_mul_pkg::mul_res_t wb_res;           // Multiplier to queue
    logic                 wb_valid;
    logic                 wb_accepted;

    mul_issue u_mul_issue (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .ops         (ops),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .rst         (rst),
        .ops         (ops),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .wb_res      (wb_res),
        .wb_valid    (wb_valid),
        .wb_accepted (wb_accepted)
    );

    mul_wb_queue u_mul_wb_queue (
        .clk         (clk),
        .rst         (rst),
        .wb_res      (wb_res),
        .wb_valid    (wb_valid),
        .wb_accepted (wb_accepted),
        .res         (res),
        .res_valid   (res_valid),
        .res_ready   (res_ready)
    );

endmodule

//--- logic/mul_wb_queue.sv
// Write-back result queue
// Circular buffer of tagged results, takes results from the multiplier
// and presents them to the register-file port in order

module mul_wb_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_mul_pkg::mul_res_t wb_res,
    input  logic                 wb_valid,
    output logic                 wb_accepted,
    output rv_mul_pkg::mul_res_t res,
    output logic                 res_valid,
    input  logic                 res_ready
);

    localparam rv_mul_pkg::wb_ptr_t LAST_PTR =
        rv_mul_pkg::wb_ptr_t'(rv_mul_pkg::WB_DEPTH - 1);
    localparam rv_mul_pkg::wb_cnt_t FULL_CNT =
        rv_mul_pkg::wb_cnt_t'(rv_mul_pkg::WB_DEPTH);

    rv_mul_pkg::mul_res_t mem [rv_mul_pkg::WB_DEPTH];   // Entry storage
    rv_mul_pkg::wb_ptr_t  wr_ptr;
    rv_mul_pkg::wb_ptr_t  rd_ptr;
    rv_mul_pkg::wb_cnt_t  count;            // Occupancy

    logic wr_en;
    logic rd_en;

    ////////////////////
    // Handshakes
    assign res_valid   = (count != '0);
    assign rd_en       = res_valid & res_ready;
    assign wb_accepted = (count < FULL_CNT) | rd_en;    // Full but draining is fine
    assign wr_en       = wb_valid & wb_accepted;

    ////////////////////
    // Pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    ////////////////////
    // Storage, no reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wb_res;
        end
    end

    // Head of queue, held while stalled
    assign res = mem[rd_ptr];

endmodule

//--- logic/mul_unit.sv
// Two-stage pipelined 33x33 signed multiplier
// Stage 1 registers operands, stage 2 registers the product;
// output word is high or low half per the op

module mul_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_mul_pkg::mul_ops_t ops,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    output rv_mul_pkg::mul_res_t wb_res,
    output logic                 wb_valid,
    input  logic                 wb_accepted
);

    // Stage 1
    logic               s1_valid;
    rv_mul_pkg::ext_t   s1_rs1;
    rv_mul_pkg::ext_t   s1_rs2;
    logic               s1_high;
    rv_mul_pkg::tag_t   s1_tag;

    // Stage 2
    logic               s2_valid;
    logic signed [65:0] s2_prod;            // Full signed product
    logic               s2_high;
    rv_mul_pkg::tag_t   s2_tag;

    logic stage1_advance;
    logic stage2_advance;
    logic issue_xfer;

    ////////////////////
    // Advance logic
    assign stage2_advance = wb_accepted | ~s2_valid;     // Drain or empty
    assign stage1_advance = stage2_advance | ~s1_valid;
    assign issue_ready    = stage1_advance;  // Same as accepted or any stage empty
    assign issue_xfer     = issue_valid & issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (stage1_advance) begin
                s1_valid <= issue_valid;
            end
            if (stage2_advance) begin
                s2_valid <= s1_valid;
            end
        end
    end

    ////////////////////
    // Stage 1, operand registers
    always_ff @(posedge clk) begin
        if (issue_xfer) begin
            s1_rs1  <= ops.rs1_ext;
            s1_rs2  <= ops.rs2_ext;
            s1_high <= ops.high;
            s1_tag  <= ops.rd_tag;
        end
    end

    ////////////////////
    // Stage 2, product register
    always_ff @(posedge clk) begin
        if (stage2_advance && s1_valid) begin
            s2_prod <= s1_rs1 * s1_rs2;     // Signed 33x33, fits in 66
            s2_high <= s1_high;             // Travels with the product
            s2_tag  <= s1_tag;
        end
    end

    ////////////////////
    // Write-back side
    assign wb_res.rd     = s2_high ? s2_prod[63:32] : s2_prod[31:0];
    assign wb_res.rd_tag = s2_tag;
    assign wb_valid      = s2_valid;

endmodule

//--- logic/mul_issue.sv
// Multiply issue stage
// Decodes operand signedness and holds one request until the
// multiplier takes it

module mul_issue (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_mul_pkg::mul_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output rv_mul_pkg::mul_ops_t ops,
    output logic                 issue_valid,
    input  logic                 issue_ready
);

    logic                 rs1_signed;       // From op decode
    logic                 rs2_signed;
    rv_mul_pkg::mul_ops_t dec_ops;          // Decoded request
    rv_mul_pkg::mul_ops_t hold_ops;         // Hold register payload
    logic                 hold_valid;
    logic                 issue_en;         // Low during reset, then stays high
    logic                 req_xfer;
    logic                 issue_xfer;

    ////////////////////
    // Op decode
    // rs1 signed for MULH, MULHSU; rs2 signed for MUL, MULH
    assign rs1_signed = req.op[1:0] inside {rv_mul_pkg::MULH_FN3[1:0],
                                            rv_mul_pkg::MULHSU_FN3[1:0]};
    assign rs2_signed = req.op[1:0] inside {rv_mul_pkg::MUL_FN3[1:0],
                                            rv_mul_pkg::MULH_FN3[1:0]};

    always_comb begin
        dec_ops.rs1_ext = {req.rs1[31] & rs1_signed, req.rs1};  // Sign or zero bit
        dec_ops.rs2_ext = {req.rs2[31] & rs2_signed, req.rs2};
        dec_ops.high    = (req.op[1:0] != rv_mul_pkg::MUL_FN3[1:0]);  // All but MUL
        dec_ops.rd_tag  = req.rd_tag;
    end

    ////////////////////
    // Handshakes
    assign issue_xfer = hold_valid & issue_ready;
    assign req_ready  = issue_en & (~hold_valid | issue_ready);  // Empty or draining
    assign req_xfer   = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_en <= 1'b0;
        end else begin
            issue_en <= 1'b1;               // Opens one cycle after reset
        end
    end

    ////////////////////
    // Hold register
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (req_xfer) begin
            hold_valid <= 1'b1;             // Refill, even while draining
        end else if (issue_xfer) begin
            hold_valid <= 1'b0;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (req_xfer) begin
            hold_ops <= dec_ops;
        end
    end

    assign ops         = hold_ops;
    assign issue_valid = hold_valid;

endmodule

//--- logic/rv_mul_pkg.sv
// RV32M multiply subsystem shared definitions
// Widths, funct3 codes, queue sizing and the request/result structs

package rv_mul_pkg;

    ////////////////////
    // Base widths
    typedef logic [31:0] xlen_t;            // Register value
    typedef logic [2:0]  funct3_t;          // M extension op selector
    typedef logic [4:0]  tag_t;             // Destination register tag

    typedef logic signed [32:0] ext_t;      // Operand after sign/zero extension

    ////////////////////
    // Multiply funct3 codes, only bits [1:0] decoded
    localparam funct3_t MUL_FN3    = 3'd0;
    localparam funct3_t MULH_FN3   = 3'd1;
    localparam funct3_t MULHSU_FN3 = 3'd2;
    localparam funct3_t MULHU_FN3  = 3'd3;

    ////////////////////
    // Write-back queue sizing
    localparam int WB_DEPTH = 4;
    localparam int WB_PTR_W = $clog2(WB_DEPTH);

    typedef logic [WB_PTR_W-1:0] wb_ptr_t;  // Read/write pointer
    typedef logic [WB_PTR_W:0]   wb_cnt_t;  // Occupancy, 0..WB_DEPTH

    ////////////////////
    // Request from the core, 72 bits
    typedef struct packed {
        funct3_t op;
        xlen_t   rs1;
        xlen_t   rs2;
        tag_t    rd_tag;
    } mul_req_t;

    // Decoded operands into the multiplier, 72 bits
    typedef struct packed {
        ext_t rs1_ext;                      // Already extended
        ext_t rs2_ext;
        logic high;                         // Take upper word
        tag_t rd_tag;
    } mul_ops_t;

    // Tagged result toward write-back, 37 bits
    typedef struct packed {
        xlen_t rd;
        tag_t  rd_tag;
    } mul_res_t;

endpackage
